/* design/bootrom_reader.sv */
`timescale 1ns/1ps

module bootrom_reader
   import tester_bus_pkg::*;
   import tester_map_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_i,
   input  apb_req_t  req_i,
   output apb_rsp_t  rsp_o,
   output logic      rom_en_o,
   output rom_addr_t rom_addr_o,
   input  data_t     rom_data_i
);

   logic wait_q;
   logic rd_acc;
   logic wr_acc;

   assign rd_acc = req_i.psel && req_i.penable && !req_i.pwrite;
   assign wr_acc = req_i.psel && req_i.penable && req_i.pwrite;

   // rom answers one cycle after the enable
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wait_q <= 1'b0;
      end else begin
         wait_q <= rd_acc && !wait_q;
      end
   end

   assign rom_en_o   = rd_acc && !wait_q;
   assign rom_addr_o = req_i.paddr[$bits(rom_addr_t)+1:2];

   assign rsp_o.prdata  = wait_q ? rom_data_i : '0;
   // read only, a write fails at once
   assign rsp_o.pready  = wait_q || wr_acc;
   assign rsp_o.pslverr = wr_acc;

endmodule

/* design/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter
   import tester_bus_pkg::*;
(
   input  logic     clk_i,
   input  logic     rst_i,
   input  apb_req_t ibus_req_i,
   input  apb_req_t dbus_req_i,
   output apb_rsp_t ibus_rsp_o,
   output apb_rsp_t dbus_rsp_o,
   output apb_req_t bus_req_o,
   input  apb_rsp_t bus_rsp_i
);

   arb_state_e state_q;
   // bit 0 ibus, bit 1 dbus, zero while idle
   logic [1:0] grant_q;
   logic       last_dbus_q;
   logic       pick_dbus;

   // on a tie the port served last yields
   assign pick_dbus = dbus_req_i.psel && (!ibus_req_i.psel || !last_dbus_q);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q     <= IDLE;
         grant_q     <= 2'b00;
         // makes ibus win the first tie
         last_dbus_q <= 1'b1;
      end else begin
         case (state_q)
            IDLE: begin
               if (ibus_req_i.psel || dbus_req_i.psel) begin
                  state_q <= SETUP;
                  grant_q <= {pick_dbus, !pick_dbus};
               end
            end
            SETUP: begin
               state_q <= ACCESS;
            end
            ACCESS: begin
               if (bus_rsp_i.pready) begin
                  state_q     <= IDLE;
                  grant_q     <= 2'b00;
                  last_dbus_q <= grant_q[1];
               end
            end
            default: begin
               state_q <= IDLE;
               grant_q <= 2'b00;
            end
         endcase
      end
   end

   // replay the granted request, phases follow our own state
   always_comb begin
      bus_req_o = grant_q[1] ? dbus_req_i : ibus_req_i;
      if (!grant_q[1]) begin
         // ibus is fetch only
         bus_req_o.pwrite = 1'b0;
      end
      bus_req_o.psel    = (state_q != IDLE);
      bus_req_o.penable = (state_q == ACCESS);
   end

   // the waiting port sees nothing, so its transfer stalls
   always_comb begin
      ibus_rsp_o = '0;
      dbus_rsp_o = '0;
      if (state_q == ACCESS) begin
         if (grant_q[1]) begin
            dbus_rsp_o = bus_rsp_i;
         end
         if (grant_q[0]) begin
            ibus_rsp_o = bus_rsp_i;
         end
      end
   end

endmodule

/* design/int_mem.sv */
`timescale 1ns/1ps

module int_mem
   import tester_bus_pkg::*;
   import tester_map_pkg::*;
(
   input  logic     clk_i,
   input  apb_req_t req_i,
   output apb_rsp_t rsp_o
);

   data_t                        mem [RAM_WORDS];
   logic [$clog2(RAM_WORDS)-1:0] word_idx;
   logic                         acc;
   logic                         wr_en;

   assign word_idx = req_i.paddr[$clog2(RAM_WORDS)+1:2];
   assign acc      = req_i.psel && req_i.penable;
   assign wr_en    = acc && req_i.pwrite;

   // only strobed lanes change
   always_ff @(posedge clk_i) begin
      if (wr_en) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (req_i.pstrb[b]) begin
               mem[word_idx][8*b +: 8] <= req_i.pwdata[8*b +: 8];
            end
         end
      end
   end

   // zero wait states
   always_comb begin
      rsp_o.prdata  = '0;
      rsp_o.pready  = acc;
      rsp_o.pslverr = 1'b0;
      if (acc && !req_i.pwrite) begin
         rsp_o.prdata = mem[word_idx];
      end
   end

endmodule

/* design/periph_split.sv */
`timescale 1ns/1ps

module periph_split
   import tester_bus_pkg::*;
   import tester_map_pkg::*;
(
   input  apb_req_t bus_req_i,
   output apb_rsp_t bus_rsp_o,
   output apb_req_t rom_req_o,
   input  apb_rsp_t rom_rsp_i,
   output apb_req_t ram_req_o,
   input  apb_rsp_t ram_rsp_i,
   output apb_req_t tmr_req_o,
   input  apb_rsp_t tmr_rsp_i
);

   target_e target;
   addr_t   rom_ofs;
   addr_t   ram_ofs;
   addr_t   tmr_ofs;
   logic    acc;

   // offsets wrap below the base, so one compare covers the range
   assign rom_ofs = bus_req_i.paddr - ROM_BASE;
   assign ram_ofs = bus_req_i.paddr - RAM_BASE;
   assign tmr_ofs = bus_req_i.paddr - TIMER_BASE;
   assign acc     = bus_req_i.psel && bus_req_i.penable;

   always_comb begin
      if (rom_ofs < REGION_SIZE) begin
         target = T_ROM;
      end else if (ram_ofs < REGION_SIZE) begin
         target = T_RAM;
      end else if (tmr_ofs[15:2] == TIMER_CTRL_OFS[15:2] ||
                   tmr_ofs[15:2] == TIMER_COUNT_OFS[15:2]) begin
         target = T_TIMER;
      end else begin
         target = T_NONE;
      end
   end

   always_comb begin
      rom_req_o      = bus_req_i;
      ram_req_o      = bus_req_i;
      tmr_req_o      = bus_req_i;
      rom_req_o.psel = bus_req_i.psel && (target == T_ROM);
      ram_req_o.psel = bus_req_i.psel && (target == T_RAM);
      tmr_req_o.psel = bus_req_i.psel && (target == T_TIMER);
   end

   always_comb begin
      case (target)
         T_ROM:   bus_rsp_o = rom_rsp_i;
         T_RAM:   bus_rsp_o = ram_rsp_i;
         T_TIMER: bus_rsp_o = tmr_rsp_i;
         default: begin
            // unmapped, answered here with an error
            bus_rsp_o.prdata  = '0;
            bus_rsp_o.pready  = acc;
            bus_rsp_o.pslverr = acc;
         end
      endcase
   end

endmodule

/* design/system_tester.sv */
`timescale 1ns/1ps

module system_tester
   import tester_bus_pkg::*;
   import tester_map_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_i,
   input  apb_req_t  ibus_req_i,
   input  apb_req_t  dbus_req_i,
   output apb_rsp_t  ibus_rsp_o,
   output apb_rsp_t  dbus_rsp_o,
   output logic      rom_en_o,
   output rom_addr_t rom_addr_o,
   input  data_t     rom_data_i
);

   // shared bus after arbitration
   apb_req_t bus_req;
   apb_rsp_t bus_rsp;

   // one link per target
   apb_req_t rom_req;
   apb_rsp_t rom_rsp;
   apb_req_t ram_req;
   apb_rsp_t ram_rsp;
   apb_req_t tmr_req;
   apb_rsp_t tmr_rsp;

   bus_arbiter u_arbiter (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .ibus_req_i(ibus_req_i),
      .dbus_req_i(dbus_req_i),
      .ibus_rsp_o(ibus_rsp_o),
      .dbus_rsp_o(dbus_rsp_o),
      .bus_req_o (bus_req),
      .bus_rsp_i (bus_rsp)
   );

   periph_split u_split (
      .bus_req_i(bus_req),
      .bus_rsp_o(bus_rsp),
      .rom_req_o(rom_req),
      .rom_rsp_i(rom_rsp),
      .ram_req_o(ram_req),
      .ram_rsp_i(ram_rsp),
      .tmr_req_o(tmr_req),
      .tmr_rsp_i(tmr_rsp)
   );

   bootrom_reader u_rom (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .req_i     (rom_req),
      .rsp_o     (rom_rsp),
      .rom_en_o  (rom_en_o),
      .rom_addr_o(rom_addr_o),
      .rom_data_i(rom_data_i)
   );

   int_mem u_ram (
      .clk_i(clk_i),
      .req_i(ram_req),
      .rsp_o(ram_rsp)
   );

   timer u_timer (
      .clk_i(clk_i),
      .rst_i(rst_i),
      .req_i(tmr_req),
      .rsp_o(tmr_rsp)
   );

endmodule

/* design/tester_bus_pkg.sv */
package tester_bus_pkg;

   // bus widths
   localparam int unsigned ADDR_W = 16;
   localparam int unsigned DATA_W = 32;
   localparam int unsigned STRB_W = DATA_W / 8;

   // byte address on the shared bus
   typedef logic [ADDR_W-1:0] addr_t;

   // one bus word
   typedef logic [DATA_W-1:0] data_t;

   // one strobe per byte lane
   typedef logic [STRB_W-1:0] strb_t;

   // requester side of an APB link
   typedef struct packed {
      addr_t paddr;
      logic  psel;
      logic  penable;
      logic  pwrite;
      data_t pwdata;
      strb_t pstrb;
   } apb_req_t;

   // completer side of an APB link
   typedef struct packed {
      data_t prdata;
      logic  pready;
      logic  pslverr;
   } apb_rsp_t;

   // arbiter sequencing of the shared bus
   typedef enum logic [1:0] {
      IDLE,
      SETUP,
      ACCESS
   } arb_state_e;

endpackage

/* design/tester_map_pkg.sv */
package tester_map_pkg;

   // region bases on the shared bus
   localparam logic [15:0] ROM_BASE    = 16'h0000;
   localparam logic [15:0] RAM_BASE    = 16'h1000;
   localparam logic [15:0] TIMER_BASE  = 16'h2000;
   localparam logic [15:0] REGION_SIZE = 16'h1000;

   // memory depths in words
   localparam int unsigned ROM_WORDS = 1024;
   localparam int unsigned RAM_WORDS = 1024;

   // word index on the external rom port
   typedef logic [$clog2(ROM_WORDS)-1:0] rom_addr_t;

   // timer registers, ctrl bit 0 is the enable
   localparam logic [15:0] TIMER_CTRL_OFS  = 16'h0000;
   localparam logic [15:0] TIMER_COUNT_OFS = 16'h0004;

   // decoded target of a shared bus access
   typedef enum logic [1:0] {
      T_ROM,
      T_RAM,
      T_TIMER,
      T_NONE
   } target_e;

endpackage

/* design/timer.sv */
`timescale 1ns/1ps

module timer
   import tester_bus_pkg::*;
   import tester_map_pkg::*;
(
   input  logic     clk_i,
   input  logic     rst_i,
   input  apb_req_t req_i,
   output apb_rsp_t rsp_o
);

   logic  enable_q;
   data_t count_q;
   logic  acc;
   logic  wr_en;
   logic  sel_ctrl;
   logic  sel_count;

   assign acc   = req_i.psel && req_i.penable;
   assign wr_en = acc && req_i.pwrite;

   // register select, the split only lets these two through
   assign sel_ctrl  = (req_i.paddr[3:2] == TIMER_CTRL_OFS[3:2]);
   assign sel_count = (req_i.paddr[3:2] == TIMER_COUNT_OFS[3:2]);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         enable_q <= 1'b0;
         count_q  <= '0;
      end else begin
         if (wr_en && sel_ctrl) begin
            enable_q <= req_i.pwdata[0];
         end
         // a load wins over the increment
         if (wr_en && sel_count) begin
            count_q <= req_i.pwdata;
         end else if (enable_q) begin
            count_q <= count_q + 1'b1;
         end
      end
   end

   always_comb begin
      rsp_o.prdata  = '0;
      rsp_o.pready  = acc;
      rsp_o.pslverr = 1'b0;
      if (acc && !req_i.pwrite) begin
         if (sel_count) begin
            rsp_o.prdata = count_q;
         end else begin
            rsp_o.prdata = {{($bits(data_t)-1){1'b0}}, enable_q};
         end
      end
   end

endmodule

/* sources.f */
design/tester_bus_pkg.sv
design/tester_map_pkg.sv
design/bus_arbiter.sv
design/periph_split.sv
design/bootrom_reader.sv
design/int_mem.sv
design/timer.sv
design/system_tester.sv
tests/system_tester_assertions.sv
tests/tb_checker.sv
tests/tb_system_tester.sv

/* tests/system_tester_assertions.sv */
`timescale 1ns/1ps

module system_tester_assertions
   import tester_bus_pkg::*;
(
   input logic     clk_i,
   input logic     rst_i,
   input apb_req_t ibus_req_i,
   input apb_req_t dbus_req_i,
   input apb_rsp_t ibus_rsp_o,
   input apb_rsp_t dbus_rsp_o,
   input apb_req_t bus_req_o,
   input apb_rsp_t bus_rsp_i
);

   // assertion failures so far
   int unsigned fail_count = 0;

   // an access cycle keeps psel and follows a cycle with psel
   penable_needs_psel: assert property (@(posedge clk_i) disable iff (rst_i)
      bus_req_o.penable |-> bus_req_o.psel && $past(bus_req_o.psel))
      else begin
         fail_count++;
         $error("downstream penable without psel or without a setup cycle");
      end

   req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      bus_req_o.psel && bus_req_o.penable && !bus_rsp_i.pready |=> $stable(bus_req_o))
      else begin
         fail_count++;
         $error("downstream request changed during wait");
      end

   ibus_ready_in_access: assert property (@(posedge clk_i) disable iff (rst_i)
      ibus_rsp_o.pready |-> ibus_req_i.psel && ibus_req_i.penable)
      else begin
         fail_count++;
         $error("ibus pready outside an access");
      end

   dbus_ready_in_access: assert property (@(posedge clk_i) disable iff (rst_i)
      dbus_rsp_o.pready |-> dbus_req_i.psel && dbus_req_i.penable)
      else begin
         fail_count++;
         $error("dbus pready outside an access");
      end

   one_ready: assert property (@(posedge clk_i) disable iff (rst_i)
      !(ibus_rsp_o.pready && dbus_rsp_o.pready))
      else begin
         fail_count++;
         $error("both ports ready in one cycle");
      end

endmodule

/* tests/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker
   import tester_bus_pkg::*;
(
   input  logic     clk_i,
   input  logic     rst_i,
   input  apb_req_t ibus_req_i,
   input  apb_req_t dbus_req_i,
   input  apb_rsp_t ibus_rsp_i,
   input  apb_rsp_t dbus_rsp_i,
   output int       errors_o
);

   data_t shadow_ram [1024];
   logic  shadow_en;
   data_t shadow_cnt;
   logic  cnt_loaded;
   int    last_port;
   logic  other_waiting;

   function automatic data_t rom_word(input logic [9:0] idx);
      return ({22'd0, idx} * 32'h0101_0101) ^ 32'hC0DE_0000;
   endfunction

   // expected {pslverr, prdata} of a completed read
   function automatic logic [32:0] expect_read(input addr_t a);
      if (a < 16'h1000) return {1'b0, rom_word(a[11:2])};
      if (a < 16'h2000) return {1'b0, shadow_ram[a[11:2]]};
      if (a[15:2] == 14'h0800) return {1'b0, 31'd0, shadow_en};
      if (a[15:2] == 14'h0801) return {1'b0, shadow_cnt};
      return {1'b1, 32'd0};
   endfunction

   task automatic check_port(input int port, input apb_req_t req, input apb_rsp_t rsp,
                             input logic other_psel);
      logic [32:0] exp;
      logic        wr;
      if (!(req.psel && req.penable && rsp.pready)) return;
      wr = (port == 1) && req.pwrite;
      exp = expect_read(req.paddr);
      if (wr) begin
         // only rom and unmapped writes fail
         exp[32] = (req.paddr < 16'h1000) || (req.paddr >= 16'h2008);
      end else if (rsp.prdata !== exp[31:0]) begin
         errors_o++;
         $display("CHECK FAILED %s addr %h expected %h actual %h",
                  tb_system_tester.test_name, req.paddr, exp[31:0], rsp.prdata);
      end
      if (rsp.pslverr !== exp[32]) begin
         errors_o++;
         $display("CHECK FAILED %s pslverr addr %h expected %b actual %b",
                  tb_system_tester.test_name, req.paddr, exp[32], rsp.pslverr);
      end
      if (port == last_port && other_waiting) begin
         errors_o++;
         $display("port %0d completed twice while the other port was waiting", port);
      end
      last_port = port;
      other_waiting = other_psel;
      if (wr && req.paddr >= 16'h1000 && req.paddr < 16'h2000) begin
         for (int b = 0; b < 4; b++) begin
            if (req.pstrb[b]) shadow_ram[req.paddr[11:2]][8*b +: 8] = req.pwdata[8*b +: 8];
         end
      end
      if (wr && req.paddr[15:2] == 14'h0800) shadow_en = req.pwdata[0];
      if (wr && req.paddr[15:2] == 14'h0801) begin
         shadow_cnt = req.pwdata;
         cnt_loaded = 1'b1;
      end
   endtask

   initial errors_o = 0;

   always @(posedge clk_i) begin
      logic inc;
      if (rst_i) begin
         shadow_en = 1'b0;
         shadow_cnt = '0;
         last_port = -1;
         other_waiting = 1'b0;
      end else begin
         inc = shadow_en;
         cnt_loaded = 1'b0;
         check_port(0, ibus_req_i, ibus_rsp_i, dbus_req_i.psel);
         check_port(1, dbus_req_i, dbus_rsp_i, ibus_req_i.psel);
         if (!cnt_loaded && inc) shadow_cnt = shadow_cnt + 1;
      end
   end

endmodule

/* tests/tb_system_tester.sv */
`timescale 1ns/1ps

module tb_system_tester
   import tester_bus_pkg::*;
   import tester_map_pkg::*;
();

   localparam int TIMEOUT = 50;

   logic      clk;
   logic      rst;
   apb_req_t  ibus_req;
   apb_req_t  dbus_req;
   apb_rsp_t  ibus_rsp;
   apb_rsp_t  dbus_rsp;
   logic      rom_en;
   rom_addr_t rom_addr;
   data_t     rom_data;
   logic [31:0] lfsr;
   int        tb_errors;
   int        chk_errors;
   int        asrt_errors;
   string     test_name;
   addr_t     ram_addrs [8];

   system_tester u_dut (
      .clk_i     (clk),
      .rst_i     (rst),
      .ibus_req_i(ibus_req),
      .dbus_req_i(dbus_req),
      .ibus_rsp_o(ibus_rsp),
      .dbus_rsp_o(dbus_rsp),
      .rom_en_o  (rom_en),
      .rom_addr_o(rom_addr),
      .rom_data_i(rom_data)
   );

   tb_checker u_checker (
      .clk_i     (clk),
      .rst_i     (rst),
      .ibus_req_i(ibus_req),
      .dbus_req_i(dbus_req),
      .ibus_rsp_i(ibus_rsp),
      .dbus_rsp_i(dbus_rsp),
      .errors_o  (chk_errors)
   );

   bind bus_arbiter system_tester_assertions u_assertions (.*);

   always #2 clk = ~clk;

   // external rom answers one cycle after the enable
   always @(posedge clk) begin
      if (rom_en) rom_data <= ({22'd0, rom_addr} * 32'h0101_0101) ^ 32'hC0DE_0000;
   end

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         v = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   // random word address inside a 4 KiB region
   function automatic addr_t rand_word_addr(input addr_t base);
      logic [31:0] v;
      v = take_bits(10);
      return base | {4'h0, v[9:0], 2'b00};
   endfunction

   function automatic strb_t rand_strb();
      logic [31:0] v;
      v = take_bits(4);
      return v[3:0];
   endfunction

   task automatic drive_port(input bit dport, input apb_req_t r);
      if (dport) begin
         dbus_req = r;
      end else begin
         ibus_req = r;
      end
   endtask

   // request stays in place so a next transfer can follow back to back
   task automatic xfer(input bit dport, input bit wr, input addr_t a, input data_t d,
                       input strb_t s);
      apb_req_t r;
      int       t;
      logic     done;
      r = '{paddr: a, psel: 1'b1, penable: 1'b0, pwrite: wr, pwdata: d, pstrb: s};
      @(negedge clk);
      drive_port(dport, r);
      @(negedge clk);
      r.penable = 1'b1;
      drive_port(dport, r);
      t = 0;
      done = 1'b0;
      while (!done && t < TIMEOUT) begin
         @(posedge clk);
         done = dport ? dbus_rsp.pready : ibus_rsp.pready;
         t++;
      end
      if (!done) begin
         tb_errors++;
         $display("timeout waiting for pready on port %0d at address %h", dport, a);
      end
   endtask

   // drop the request after the last transfer of a sequence
   task automatic idle_port(input bit dport);
      @(negedge clk);
      drive_port(dport, '0);
   endtask

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      ibus_req = '0;
      dbus_req = '0;
      rom_data = '0;
      lfsr = 32'h4dfa_c80f;
      tb_errors = 0;
      asrt_errors = 0;
      test_name = "reset";
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      if (ibus_rsp.pready || dbus_rsp.pready || rom_en) begin
         tb_errors++;
         $display("pready or rom_en high right after reset");
      end

      test_name = "rom";
      for (int i = 0; i < 8; i++) xfer(0, 0, rand_word_addr(ROM_BASE), '0, '0);
      idle_port(0);
      xfer(1, 1, 16'h0040, 32'h1234_5678, 4'hf);

      test_name = "ram";
      for (int i = 0; i < 8; i++) begin
         ram_addrs[i] = rand_word_addr(RAM_BASE);
         xfer(1, 1, ram_addrs[i], take_bits(32), 4'hf);
         xfer(1, 1, ram_addrs[i], take_bits(32), rand_strb());
      end
      for (int i = 0; i < 8; i++) xfer(1, 0, ram_addrs[i], '0, '0);
      idle_port(1);

      // ibus is read only, the ram word must stay as it was
      test_name = "ibus write";
      xfer(0, 1, ram_addrs[0], 32'hdead_beef, 4'hf);
      idle_port(0);
      xfer(1, 0, ram_addrs[0], '0, '0);

      test_name = "timer";
      xfer(1, 1, TIMER_BASE + TIMER_CTRL_OFS, 32'd0, 4'hf);
      xfer(1, 1, TIMER_BASE + TIMER_COUNT_OFS, take_bits(32), 4'hf);
      xfer(1, 0, TIMER_BASE + TIMER_COUNT_OFS, '0, '0);
      xfer(1, 1, TIMER_BASE + TIMER_CTRL_OFS, 32'd1, 4'hf);
      xfer(1, 0, TIMER_BASE + TIMER_CTRL_OFS, '0, '0);
      xfer(1, 0, TIMER_BASE + TIMER_COUNT_OFS, '0, '0);
      xfer(1, 0, TIMER_BASE + TIMER_COUNT_OFS, '0, '0);

      test_name = "unmapped";
      xfer(1, 0, 16'h3000, '0, '0);
      xfer(1, 0, 16'h2008, '0, '0);
      idle_port(1);
      xfer(0, 0, 16'h3000, '0, '0);
      idle_port(0);

      // both ports keep a request pending, so every grant is a tie
      test_name = "contention";
      fork
         begin
            for (int i = 0; i < 10; i++) xfer(0, 0, rand_word_addr(ROM_BASE), '0, '0);
            idle_port(0);
         end
         begin
            for (int i = 0; i < 10; i++) xfer(1, 0, ram_addrs[i % 8], '0, '0);
            idle_port(1);
         end
      join

      repeat (2) @(negedge clk);
      asrt_errors = u_dut.u_arbiter.u_assertions.fail_count;
      $display("checker errors %0d, testbench errors %0d, assertion errors %0d",
               chk_errors, tb_errors, asrt_errors);
      if (chk_errors == 0 && tb_errors == 0 && asrt_errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
